//--- flist.f
+incdir+src
src/compress_pkg.sv
src/packet_pkg.sv
src/fetch_ctrl.sv
src/group_fifo.sv
src/unit_expander.sv
src/decompressor.sv
verif/decompressor_props.sv
verif/decompressor_tb.sv

//--- run.sh
#!/bin/sh
# builds the decompressor testbench with Verilator and runs it,
# the exit status follows the pass line in the simulation output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module decompressor_tb -o sim_decompressor \
    && ./obj_dir/sim_decompressor | tee /dev/stderr | grep -q "^PASS: all tests$" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- src/compress_pkg.sv
`include "decomp_defines.svh"
`default_nettype none

// memory-side view of the zero-run compressed feature map
package compress_pkg;

    // info bits left over at the top of a group once the units are packed
    localparam int INFO_W = `MEM_BANDWIDTH * 8 - `UNITS_PER_GROUP * (`UNIT_ZERO_W + `VAL_W);

    // one unit expands to zero bytes followed by its value byte
    typedef struct packed {
        logic [`VAL_W-1:0]      val;  // sits above the zero count
        logic [`UNIT_ZERO_W-1:0] zero; // number of zero bytes before val
    } compress_unit_t;

    // a 64-bit group as it comes back from memory
    typedef struct packed {
        logic                                  end_with_val; // bit 63, last unit keeps its value
        logic [INFO_W-2:0]                     last_unit;    // index of the final unit, 7 if none
        compress_unit_t [`UNITS_PER_GROUP-1:0] units;        // unit 0 in bits 11..0
    } compress_group_t;

    // buffer pointer, the extra top bit flips on every wrap
    typedef logic [$clog2(`DATA_FIFO_DEPTH):0] fifo_ptr_t;

endpackage

`default_nettype wire

//--- src/decomp_defines.svh
`ifndef DECOMP_DEFINES_SVH
`define DECOMP_DEFINES_SVH

// bytes delivered by one memory beat, one compress group per beat
`define MEM_BANDWIDTH 8

// group buffer entries, sized to cover the memory round trip
`define DATA_FIFO_DEPTH 16

// compress units packed into the low 60 bits of a group
`define UNITS_PER_GROUP 5

// zero-run field of a unit, so a run is 0 to 15 bytes long
`define UNIT_ZERO_W 4

// one feature-map element
`define VAL_W 8

// elements per packet towards the feature-map buffer
`define PACKET_ELEMS 8

// last_unit code saying every unit of the group is in use and the stream goes on
`define END_ALL_VALID 7

`endif

//--- src/decompressor.sv
`timescale 1ns/1ps
`default_nettype none

// zero-run decompressor: memory fetch, group buffer, byte expander
module decompressor (
    input  logic                           layer23_gated_clk,
    input  logic                           rst_n,
    input  logic                           start,            // begins a new stream
    input  logic                           ifmap_buffer_req, // level from the feature-map buffer
    input  logic                           mem_ack,
    input  logic                           mem_data_valid,
    input  compress_pkg::compress_group_t  mem_data,
    output logic                           mem_req,
    output logic                           decompressor_ack, // a packet is on offer
    output packet_pkg::decompress_packet_t decompress_packet
);
    import compress_pkg::*;

    logic            wr_en;     // returned group goes into the buffer
    compress_group_t wr_group;
    compress_group_t head;      // oldest buffered group
    logic            not_empty;
    logic            pop;       // also frees a fetch slot in fetch_ctrl

    fetch_ctrl u_fetch_ctrl (
        .layer23_gated_clk (layer23_gated_clk),
        .rst_n             (rst_n),
        .start             (start),
        .mem_ack           (mem_ack),
        .mem_data_valid    (mem_data_valid),
        .pop               (pop),
        .mem_data          (mem_data),
        .mem_req           (mem_req),
        .wr_en             (wr_en),
        .wr_group          (wr_group)
    );

    group_fifo u_group_fifo (
        .layer23_gated_clk (layer23_gated_clk),
        .rst_n             (rst_n),
        .start             (start),
        .wr_en             (wr_en),
        .pop               (pop),
        .wr_group          (wr_group),
        .head              (head),
        .not_empty         (not_empty)
    );

    unit_expander u_unit_expander (
        .layer23_gated_clk (layer23_gated_clk),
        .rst_n             (rst_n),
        .start             (start),
        .ifmap_buffer_req  (ifmap_buffer_req),
        .not_empty         (not_empty),
        .head              (head),
        .pop               (pop),
        .decompressor_ack  (decompressor_ack),
        .packet            (decompress_packet)
    );

endmodule

`default_nettype wire

//--- src/fetch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "decomp_defines.svh"

// issues memory fetches and turns returned beats into buffer writes
module fetch_ctrl (
    input  logic                          layer23_gated_clk,
    input  logic                          rst_n,
    input  logic                          start,          // clears the fetch state, one cycle
    input  logic                          mem_ack,        // fetch accepted when seen with mem_req
    input  logic                          mem_data_valid, // one returned group, in request order
    input  logic                          pop,            // expander released a buffer entry
    input  compress_pkg::compress_group_t mem_data,
    output logic                          mem_req,
    output logic                          wr_en,
    output compress_pkg::compress_group_t wr_group
);
    import compress_pkg::*;

    logic      enable;      // armed by start, stays armed until reset
    logic      end_seen;    // end group already written for this stream
    fifo_ptr_t outstanding; // accepted fetches whose entry has not been popped yet
    logic      accept;
    logic      is_end_group;

    // every accepted fetch owns a buffer entry until the expander pops it,
    // so keeping this below depth means a returning group always has room
    assign mem_req = enable && !end_seen && !start && (outstanding < `DATA_FIFO_DEPTH);
    assign accept  = mem_req && mem_ack;

    // groups arriving after the end group belong to no stream and are dropped
    assign wr_en    = enable && !end_seen && !start && mem_data_valid;
    assign wr_group = mem_data;

    // any last_unit code other than 7 marks the final group
    assign is_end_group = mem_data.last_unit != (INFO_W - 1)'(`END_ALL_VALID);

    always_ff @(posedge layer23_gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            enable <= 1'b0;
        end else if (start) begin
            enable <= 1'b1; // mem_req can rise from the next cycle
        end
    end

    // set on the write edge of the end group, mem_req drops in the cycle after
    always_ff @(posedge layer23_gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            end_seen <= 1'b0;
        end else if (start) begin
            end_seen <= 1'b0;
        end else if (wr_en && is_end_group) begin
            end_seen <= 1'b1;
        end
    end

    always_ff @(posedge layer23_gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            outstanding <= '0;
        end else if (start) begin
            outstanding <= '0;
        end else if (accept && !pop) begin
            outstanding <= outstanding + 1'b1;
        end else if (pop && !accept) begin
            outstanding <= outstanding - 1'b1; // both at once leaves the count as it is
        end
    end

endmodule

`default_nettype wire

//--- src/group_fifo.sv
`timescale 1ns/1ps
`default_nettype none
`include "decomp_defines.svh"

// holds compress groups between the memory return and the expander
module group_fifo (
    input  logic                          layer23_gated_clk,
    input  logic                          rst_n,
    input  logic                          start,     // empties the buffer
    input  logic                          wr_en,
    input  logic                          pop,       // head consumed at this edge
    input  compress_pkg::compress_group_t wr_group,
    output compress_pkg::compress_group_t head,
    output logic                          not_empty
);
    import compress_pkg::*;

    localparam int IDX_W = $clog2(`DATA_FIFO_DEPTH);

    compress_group_t mem [`DATA_FIFO_DEPTH]; // payload only, pointers say what is live
    fifo_ptr_t       wr_ptr;
    fifo_ptr_t       rd_ptr;
    logic            full;
    logic            do_write;
    logic            do_pop;

    // same slot on different laps means every entry is taken
    assign full      = (wr_ptr[IDX_W-1:0] == rd_ptr[IDX_W-1:0]) && (wr_ptr[IDX_W] != rd_ptr[IDX_W]);
    assign not_empty = wr_ptr != rd_ptr; // a write shows up here one cycle later

    // fetch_ctrl already bounds the fetches, these guards only keep the pointers sane
    assign do_write = wr_en && !full;
    assign do_pop   = pop && not_empty;

    assign head = mem[rd_ptr[IDX_W-1:0]];

    always_ff @(posedge layer23_gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (start) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge layer23_gated_clk) begin
        if (do_write) begin
            mem[wr_ptr[IDX_W-1:0]] <= wr_group;
        end
    end

endmodule

`default_nettype wire

//--- src/packet_pkg.sv
`include "decomp_defines.svh"
`default_nettype none

// output side: what the feature-map buffer receives and how the expander walks a group
package packet_pkg;

    // one transfer towards the feature-map buffer
    typedef struct packed {
        logic                                   packet_valid; // mirrored on decompressor_ack
        logic [`PACKET_ELEMS-1:0]               valid_mask;   // bit i set when data[i] holds a byte
        logic [`PACKET_ELEMS-1:0][`VAL_W-1:0]   data;         // element 0 in the low byte
    } decompress_packet_t;

    // expander position inside the current unit
    typedef enum logic [1:0] {
        EXP_IDLE  = 2'd0, // at the start of a unit, nothing taken from it yet
        EXP_ZEROS = 2'd1, // emitting the rest of the zero run
        EXP_VALUE = 2'd2, // zeros done, value byte (or the stream end) is next
        EXP_DONE  = 2'd3  // stream finished, waiting for the next start
    } expand_state_t;

endpackage

`default_nettype wire

//--- src/unit_expander.sv
`timescale 1ns/1ps
`default_nettype none
`include "decomp_defines.svh"

// expands the head group one byte per cycle and packs the bytes into packets
module unit_expander (
    input  logic                           layer23_gated_clk,
    input  logic                           rst_n,
    input  logic                           start,
    input  logic                           ifmap_buffer_req, // downstream can take the packet
    input  logic                           not_empty,
    input  compress_pkg::compress_group_t  head,
    output logic                           pop,              // one pulse per finished group
    output logic                           decompressor_ack,
    output packet_pkg::decompress_packet_t packet
);
    import compress_pkg::*;
    import packet_pkg::*;

    localparam int UNIT_IDX_W = $clog2(`UNITS_PER_GROUP);
    localparam int SLOT_W     = $clog2(`PACKET_ELEMS);

    expand_state_t                        state;
    expand_state_t                        state_next;
    logic [UNIT_IDX_W-1:0]                unit_idx;   // unit of the head group being expanded
    logic [UNIT_IDX_W-1:0]                idx_next;
    logic [`UNIT_ZERO_W-1:0]              zero_left;  // zeros still owed by the current unit
    logic [`UNIT_ZERO_W-1:0]              zero_next;
    logic [`UNIT_ZERO_W-1:0]              pend_zeros;
    logic [`PACKET_ELEMS-1:0][`VAL_W-1:0] asm_data;   // assembly register
    logic [SLOT_W:0]                      asm_cnt;    // bytes in the assembly register, 0 to 8
    logic [SLOT_W:0]                      base_cnt;
    logic                                 out_valid;
    logic [`PACKET_ELEMS-1:0]             out_mask;
    logic [`PACKET_ELEMS-1:0][`VAL_W-1:0] out_data;
    logic [`PACKET_ELEMS-1:0]             flush_mask;
    logic [`PACKET_ELEMS-1:0][`VAL_W-1:0] flush_data;
    compress_unit_t                       cur_unit;
    logic                                 is_last_unit;
    logic                                 handshake;
    logic                                 out_free;
    logic                                 flush_req;
    logic                                 move;
    logic                                 step;
    logic                                 emit;
    logic [`VAL_W-1:0]                    emit_byte;

    assign cur_unit = head.units[unit_idx];

    // the final unit of the stream, only in a group whose info code is not 7
    assign is_last_unit = (head.last_unit != (INFO_W - 1)'(`END_ALL_VALID)) &&
                          (unit_idx == head.last_unit);

    assign handshake = out_valid && ifmap_buffer_req; // packet leaves at this edge
    assign out_free  = !out_valid || handshake;

    // a full assembly moves on, and so does a partial one once the stream has ended
    assign flush_req = (asm_cnt == (SLOT_W + 1)'(`PACKET_ELEMS)) ||
                       ((state == EXP_DONE) && (asm_cnt != '0));
    assign move      = flush_req && out_free;

    // on a move the next byte lands in slot 0 of a fresh assembly
    assign base_cnt = move ? '0 : asm_cnt;

    // stalls while the assembly is full and the output packet is still held
    assign step = (state != EXP_DONE) && not_empty && !start &&
                  (base_cnt != (SLOT_W + 1)'(`PACKET_ELEMS));

    always_comb begin
        case (state)
            EXP_IDLE:  pend_zeros = cur_unit.zero; // fresh unit, count straight from the group
            EXP_ZEROS: pend_zeros = zero_left;
            default:   pend_zeros = '0;
        endcase
    end

    always_comb begin
        emit       = 1'b0;
        emit_byte  = '0;
        state_next = state;
        zero_next  = zero_left;
        idx_next   = unit_idx;
        pop        = 1'b0;
        if (step) begin
            if (pend_zeros != '0) begin
                emit       = 1'b1; // a zero of the run
                zero_next  = pend_zeros - 1'b1;
                state_next = (pend_zeros == 1) ? EXP_VALUE : EXP_ZEROS;
            end else begin
                // the final unit may end on its zeros and then has no value byte
                emit      = !is_last_unit || head.end_with_val;
                emit_byte = cur_unit.val;
                if (is_last_unit) begin
                    pop        = 1'b1;
                    idx_next   = '0;
                    state_next = EXP_DONE;
                end else if (unit_idx == UNIT_IDX_W'(`UNITS_PER_GROUP - 1)) begin
                    pop        = 1'b1; // full group used up, the next one becomes head
                    idx_next   = '0;
                    state_next = EXP_IDLE;
                end else begin
                    idx_next   = unit_idx + 1'b1;
                    state_next = EXP_IDLE;
                end
            end
        end
    end

    // only the filled slots are valid, the rest go out as zero
    always_comb begin
        for (int i = 0; i < `PACKET_ELEMS; i++) begin
            flush_mask[i] = i < asm_cnt;
            flush_data[i] = flush_mask[i] ? asm_data[i] : '0;
        end
    end

    always_ff @(posedge layer23_gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= EXP_IDLE;
            unit_idx  <= '0;
            zero_left <= '0;
            asm_cnt   <= '0;
            out_valid <= 1'b0;
        end else if (start) begin
            state     <= EXP_IDLE; // drops any leftover of the previous stream
            unit_idx  <= '0;
            zero_left <= '0;
            asm_cnt   <= '0;
            out_valid <= 1'b0;
        end else begin
            state     <= state_next;
            unit_idx  <= idx_next;
            zero_left <= zero_next;
            asm_cnt   <= base_cnt + (SLOT_W + 1)'(emit);
            if (move) begin
                out_valid <= 1'b1;
            end else if (handshake) begin
                out_valid <= 1'b0;
            end
        end
    end

    // the output payload only changes on a move so it holds under back-pressure
    always_ff @(posedge layer23_gated_clk) begin
        if (emit) begin
            asm_data[base_cnt[SLOT_W-1:0]] <= emit_byte;
        end
        if (move) begin
            out_mask <= flush_mask;
            out_data <= flush_data;
        end
    end

    assign packet = '{packet_valid: out_valid, valid_mask: out_mask, data: out_data};
    assign decompressor_ack = packet.packet_valid;

endmodule

`default_nettype wire

//--- verif/decompressor_props.sv
`timescale 1ns/1ps
`default_nettype none
`include "decomp_defines.svh"

// protocol checks bound into the decompressor top level
module decompressor_props (
    input logic                           layer23_gated_clk,
    input logic                           rst_n,
    input logic                           start,
    input logic                           mem_req,
    input logic                           mem_ack,
    input logic                           pop,
    input logic                           decompressor_ack,
    input logic                           ifmap_buffer_req,
    input packet_pkg::decompress_packet_t decompress_packet
);
    int   in_flight; // fetches accepted and not yet popped
    logic started;   // a start has been seen since reset

    always_ff @(posedge layer23_gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            in_flight <= 0;
            started   <= 1'b0;
        end else if (start) begin
            in_flight <= 0; // start drops whatever the buffer still held
            started   <= 1'b1;
        end else begin
            in_flight <= in_flight + int'(mem_req && mem_ack) - int'(pop);
        end
    end

    a_fetch_bound: assert property (@(posedge layer23_gated_clk) disable iff (!rst_n)
        in_flight <= `DATA_FIFO_DEPTH)
        else $error("more fetches outstanding than buffer entries");

    // an offered packet that is not taken stays on offer unchanged
    a_packet_hold: assert property (@(posedge layer23_gated_clk) disable iff (!rst_n)
        decompressor_ack && !ifmap_buffer_req && !start |=>
            decompressor_ack && $stable(decompress_packet))
        else $error("packet changed while held by back-pressure");

    a_idle_until_start: assert property (@(posedge layer23_gated_clk) disable iff (!rst_n)
        !started |-> !mem_req)
        else $error("memory request before the first start");

endmodule

`default_nettype wire

//--- verif/decompressor_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "decomp_defines.svh"

// directed testbench for the zero-run decompressor with a memory model and a packet sink
module decompressor_tb;
    import compress_pkg::*;
    import packet_pkg::*;

    localparam int MAX_CYCLES  = 4000; // well beyond the length of all streams together
    localparam int MEM_LATENCY = 3;    // cycles from an accepted fetch to its data strobe

    logic               layer23_gated_clk;
    logic               rst_n;
    logic               start;
    logic               ifmap_buffer_req;
    logic               mem_ack;
    logic               mem_data_valid;
    compress_group_t    mem_data;
    logic               mem_req;
    logic               decompressor_ack;
    decompress_packet_t decompress_packet;

    compress_group_t    grp_q[$];     // groups of the current stream in memory order
    logic [`VAL_W-1:0]  exp_bytes[$]; // reference byte stream
    decompress_packet_t got_q[$];     // packets taken by the sink
    int                 due_q[$];     // return cycle of each accepted fetch
    int                 cycle_cnt;
    int                 acks;
    int                 ret_idx;
    int                 value_errs;
    int                 other_errs;
    logic               back_pressure;
    logic               last_sent;    // the stream's final group went out on the bus
    logic               stop_watch;   // from here on mem_req must stay low

    decompressor u_decompressor (
        .layer23_gated_clk (layer23_gated_clk),
        .rst_n             (rst_n),
        .start             (start),
        .ifmap_buffer_req  (ifmap_buffer_req),
        .mem_ack           (mem_ack),
        .mem_data_valid    (mem_data_valid),
        .mem_data          (mem_data),
        .mem_req           (mem_req),
        .decompressor_ack  (decompressor_ack),
        .decompress_packet (decompress_packet)
    );

    // connections resolve inside the decompressor scope
    bind decompressor decompressor_props u_decompressor_props (
        .layer23_gated_clk (layer23_gated_clk),
        .rst_n             (rst_n),
        .start             (start),
        .mem_req           (mem_req),
        .mem_ack           (mem_ack),
        .pop               (pop),
        .decompressor_ack  (decompressor_ack),
        .ifmap_buffer_req  (ifmap_buffer_req),
        .decompress_packet (decompress_packet)
    );

    initial begin
        layer23_gated_clk = 1'b0;
        forever #4 layer23_gated_clk = ~layer23_gated_clk; // 8 ns period
    end

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge layer23_gated_clk);
            cycle_cnt++;
        end
        $display("timeout: the run went past %0d cycles without finishing", MAX_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    // memory acks at random and answers in order
    // past its own groups it acks again only once the end group is written,
    // so a fetch issued after the end shows up in the ack count
    initial begin : memory_model
        logic        fire;
        mem_ack        = 1'b0;
        mem_data_valid = 1'b0;
        mem_data       = '0;
        forever begin
            @(negedge layer23_gated_clk);
            fire = mem_req && mem_ack; // fetch taken at the coming edge
            if (stop_watch) begin
                check_level("mem_req", mem_req, 1'b0);
            end
            @(posedge layer23_gated_clk);
            #1;
            if (last_sent) begin
                stop_watch = 1'b1; // end group was written at this edge
            end
            if (fire) begin
                acks++;
                due_q.push_back(cycle_cnt + MEM_LATENCY);
            end
            mem_data_valid = 1'b0;
            if (due_q.size() > 0 && due_q[0] <= cycle_cnt && ret_idx < grp_q.size()) begin
                void'(due_q.pop_front());
                mem_data       = grp_q[ret_idx];
                mem_data_valid = 1'b1;
                ret_idx++;
                last_sent      = ret_idx == grp_q.size();
            end
            mem_ack = (acks < grp_q.size() || stop_watch) && ($urandom % 4 != 0);
        end
    end

    // sink takes a packet whenever ack and req meet and req drops for random stretches
    initial begin : sink_model
        int stretch;
        stretch          = 0;
        ifmap_buffer_req = 1'b0;
        forever begin
            @(negedge layer23_gated_clk);
            if (decompressor_ack && ifmap_buffer_req) begin
                got_q.push_back(decompress_packet);
            end
            @(posedge layer23_gated_clk);
            #1;
            if (!back_pressure) begin
                ifmap_buffer_req = 1'b1;
            end else if (stretch == 0) begin
                ifmap_buffer_req = ($urandom % 2) == 0;
                stretch          = 1 + $urandom % 6; // length of the next stretch
            end else begin
                stretch--;
            end
        end
    end

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h at cycle %0d", name, got, exp, cycle_cnt);
            value_errs++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("FAIL %s: got %0h expected %0h", name, got, exp);
            value_errs++;
        end
    endtask

    // bytes are only compared in the slots the expected mask marks as filled
    task automatic check_packet(input string test, input int idx,
                                input decompress_packet_t got, input decompress_packet_t exp);
        if (got.packet_valid !== exp.packet_valid) begin
            $display("FAIL decompress_packet.packet_valid (%s, packet %0d): got %h expected %h",
                     test, idx, got.packet_valid, exp.packet_valid);
            value_errs++;
        end
        if (got.valid_mask !== exp.valid_mask) begin
            $display("FAIL decompress_packet.valid_mask (%s, packet %0d): got %h expected %h",
                     test, idx, got.valid_mask, exp.valid_mask);
            value_errs++;
        end
        for (int b = 0; b < `PACKET_ELEMS; b++) begin
            if (exp.valid_mask[b] && got.data[b] !== exp.data[b]) begin
                $display("FAIL decompress_packet.data[%0d] (%s, packet %0d): got %h expected %h",
                         b, test, idx, got.data[b], exp.data[b]);
                value_errs++;
            end
        end
    endtask

    // a unit gives its zeros then its value
    // and the stream's last unit keeps the value only on request
    task automatic build_expected();
        compress_unit_t u;
        logic           is_end;
        exp_bytes.delete();
        foreach (grp_q[g]) begin
            for (int k = 0; k < `UNITS_PER_GROUP; k++) begin
                u      = grp_q[g].units[k];
                is_end = int'(grp_q[g].last_unit) != `END_ALL_VALID &&
                         k == int'(grp_q[g].last_unit);
                repeat (u.zero) exp_bytes.push_back(8'h00);
                if (!is_end || grp_q[g].end_with_val) begin
                    exp_bytes.push_back(u.val);
                end
                if (is_end) begin
                    return;
                end
            end
        end
    endtask

    // appends n groups of random units and the final one ends the stream at last_idx
    task automatic add_random_groups(input int n, input logic [2:0] last_idx, input logic with_val);
        compress_group_t g;
        logic [31:0]     rnd;
        for (int i = 0; i < n; i++) begin
            for (int k = 0; k < `UNITS_PER_GROUP; k++) begin
                rnd             = $urandom;
                g.units[k].zero = rnd[3:0]; // runs of 0 to 15
                g.units[k].val  = rnd[11:4];
            end
            g.end_with_val = (i == n - 1) ? with_val : 1'b0;
            g.last_unit    = (i == n - 1) ? last_idx : 3'd7;
            grp_q.push_back(g);
        end
    endtask

    // starts the stream held in grp_q and checks packets, fetch count and idle outputs
    task automatic run_stream(input string test);
        decompress_packet_t exp;
        int                 n_pkts;
        int                 n_left;
        build_expected();
        n_pkts = (exp_bytes.size() + `PACKET_ELEMS - 1) / `PACKET_ELEMS;
        @(posedge layer23_gated_clk);
        #2;
        got_q.delete();
        due_q.delete();
        acks       = 0;
        ret_idx    = 0;
        last_sent  = 1'b0;
        stop_watch = 1'b0;
        @(posedge layer23_gated_clk);
        #1;
        start = 1'b1;
        @(posedge layer23_gated_clk);
        #1;
        start = 1'b0;
        while (got_q.size() < n_pkts) @(posedge layer23_gated_clk);
        repeat (20) @(posedge layer23_gated_clk); // room for a stray extra packet to show up
        @(negedge layer23_gated_clk);
        if (got_q.size() != n_pkts) begin
            $display("%s: received %0d packets but expected %0d", test, got_q.size(), n_pkts);
            other_errs++;
        end
        for (int p = 0; p < n_pkts && p < got_q.size(); p++) begin
            n_left           = exp_bytes.size() - p * `PACKET_ELEMS;
            exp.packet_valid = 1'b1;
            exp.valid_mask   = (n_left >= `PACKET_ELEMS) ? 8'hff : (8'h01 << n_left) - 8'h01;
            for (int b = 0; b < `PACKET_ELEMS; b++) begin
                exp.data[b] = (b < n_left) ? exp_bytes[p * `PACKET_ELEMS + b] : 8'h00;
            end
            check_packet(test, p, got_q[p], exp);
        end
        check_level("decompressor_ack", decompressor_ack, 1'b0);
        check_level("mem_req", mem_req, 1'b0);
        check_count("mem_ack count", acks, grp_q.size()); // one fetch per group and none after
    endtask

    task automatic test_reset_idle();
        repeat (3) @(negedge layer23_gated_clk);
        check_level("mem_req", mem_req, 1'b0);
        check_level("decompressor_ack", decompressor_ack, 1'b0);
    endtask

    // 3+1, 0+1 and 5+1 bytes while units 3 and 4 lie past the end and must not appear
    task automatic test_single_group();
        compress_group_t g;
        g.end_with_val = 1'b1;
        g.last_unit    = 3'd2;
        g.units[0]     = '{val: 8'h11, zero: 4'd3};
        g.units[1]     = '{val: 8'h22, zero: 4'd0};
        g.units[2]     = '{val: 8'h33, zero: 4'd5};
        g.units[3]     = '{val: 8'hee, zero: 4'd15};
        g.units[4]     = '{val: 8'hdd, zero: 4'd9};
        grp_q.delete();
        grp_q.push_back(g);
        run_stream("single group");
    endtask

    task automatic test_multi_group();
        grp_q.delete();
        add_random_groups(5, 3'd3, 1'b0); // final unit ends on its zeros
        run_stream("multi group");
    endtask

    // more groups than buffer entries so the fetch bound is reached while the sink stalls
    task automatic test_back_pressure();
        back_pressure = 1'b1;
        grp_q.delete();
        add_random_groups(18, 3'd4, 1'b1);
        run_stream("back-pressure");
        back_pressure = 1'b0;
    endtask

    task automatic test_fetch_stop();
        grp_q.delete();
        add_random_groups(3, 3'd0, 1'b0);
        run_stream("fetch stop");
    endtask

    task automatic test_restart();
        grp_q.delete();
        add_random_groups(4, 3'd1, 1'b1);
        run_stream("restart");
    endtask

    initial begin : main
        void'($urandom(91649)); // one seed for the whole run
        rst_n         = 1'b0;
        start         = 1'b0;
        back_pressure = 1'b0;
        last_sent     = 1'b0;
        stop_watch    = 1'b0;
        acks          = 0;
        ret_idx       = 0;
        value_errs    = 0;
        other_errs    = 0;
        repeat (10) @(posedge layer23_gated_clk);
        #1;
        rst_n = 1'b1;
        test_reset_idle();
        test_single_group();
        test_multi_group();
        test_back_pressure();
        test_fetch_stop();
        test_restart();
        $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
